// File: common/gpu_pkg.sv
package gpu_pkg;

  // ====================
  // Data and index types
  // ====================

  typedef logic [63:0]        word_t;
  typedef logic signed [15:0] lane_t;
  typedef logic [31:0]        instr_t;
  typedef logic [2:0]         reg_idx_t;
  typedef logic [9:0]         tid_t;

  localparam int NUM_LANES = 4;
  localparam int NUM_REGS  = 8;

  // Codes not listed here decode as NOP
  typedef enum logic [3:0] {
    NOP    = 4'h0,
    LI     = 4'h1,
    LD     = 4'h2,
    ST     = 4'h3,
    ADD    = 4'h4,
    SUB    = 4'h5,
    RELU   = 4'h7,
    SETTID = 4'h8,
    INCTID = 4'h9,
    BLT    = 4'hA,
    JMP    = 4'hE,
    HALT   = 4'hF
  } opcode_t;

  typedef enum logic [1:0] {
    BASE_A = 2'd0,
    BASE_B = 2'd1,
    BASE_C = 2'd2
  } base_sel_t;

  // ====================
  // Instruction fields
  // ====================

  localparam int OP_HI   = 31;
  localparam int OP_LO   = 28;
  localparam int RD_HI   = 27;
  localparam int RD_LO   = 25;
  localparam int RS1_HI  = 24;
  localparam int RS1_LO  = 22;
  localparam int RS2_HI  = 21;
  localparam int RS2_LO  = 19;
  localparam int BSEL_HI = 18;
  localparam int BSEL_LO = 17;
  localparam int IMM_HI  = 15;
  localparam int IMM_LO  = 0;

  localparam instr_t INSTR_NOP = '0;

endpackage

// File: hdl/gpu_dmem.sv
`timescale 1ns/1ps

module gpu_dmem #(
  parameter int DMEM_AW = 10
) (
  input  logic                clk,
  input  logic                core_we,
  input  logic [DMEM_AW-1:0]  core_addr,
  input  gpu_pkg::word_t      core_wdata,
  output gpu_pkg::word_t      core_rdata,
  input  logic                host_dmem_we,
  input  logic [DMEM_AW-1:0]  host_dmem_addr,
  input  gpu_pkg::word_t      host_dmem_wdata,
  output gpu_pkg::word_t      host_dmem_rdata
);
  import gpu_pkg::*;

  word_t              mem [2**DMEM_AW];
  logic               wr_en;
  logic [DMEM_AW-1:0] wr_addr;
  word_t              wr_data;

  // Single write port, host wins
  always_comb begin
    wr_en   = host_dmem_we | core_we;
    wr_addr = host_dmem_we ? host_dmem_addr : core_addr;
    wr_data = host_dmem_we ? host_dmem_wdata : core_wdata;
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    core_rdata      <= mem[core_addr];
    host_dmem_rdata <= mem[host_dmem_addr];
  end

  // Host loads only while the core is stopped
  a_one_writer: assert property (
    @(posedge clk) !(host_dmem_we && core_we)
  );

endmodule

// File: core/gpu_fetch.sv
`timescale 1ns/1ps

module gpu_fetch #(
  parameter int IMEM_AW = 8
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                imem_we,
  input  logic [IMEM_AW-1:0]  imem_waddr,
  input  gpu_pkg::instr_t     imem_wdata,
  input  logic                advance,
  input  logic                redirect,
  input  logic [IMEM_AW-1:0]  redirect_pc,
  output gpu_pkg::instr_t     instr
);
  import gpu_pkg::*;

  instr_t             imem [2**IMEM_AW];
  instr_t             imem_rdata;
  logic [IMEM_AW-1:0] pc;
  logic [IMEM_AW-1:0] pc_inc;
  logic [IMEM_AW-1:0] pc_next;
  logic [IMEM_AW-1:0] rd_addr;
  logic               kill;

  assign pc_inc = pc + 1'b1;

  // pc holds the address of the word shown on instr
  always_comb begin
    if (redirect) begin
      // Shadow slot fetches the fall-through word, killed below
      pc_next = redirect_pc;
      rd_addr = pc_inc;
    end else if (advance && !kill) begin
      pc_next = pc_inc;
      rd_addr = pc_inc;
    end else begin
      pc_next = pc;
      rd_addr = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_waddr] <= imem_wdata;
    end
    imem_rdata <= imem[rd_addr];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc   <= '0;
      kill <= 1'b0;
    end else begin
      pc   <= pc_next;
      kill <= redirect;
    end
  end

  assign instr = kill ? INSTR_NOP : imem_rdata;

  // A taken branch never also steps the counter
  a_adv_redir: assert property (
    @(posedge clk) disable iff (rst) !(advance && redirect)
  );

endmodule

// File: core/gpu_regfile.sv
`timescale 1ns/1ps

module gpu_regfile (
  input  logic               clk,
  input  logic               rst,
  input  gpu_pkg::reg_idx_t  rs1_idx,
  input  gpu_pkg::reg_idx_t  rs2_idx,
  input  logic               rf_we,
  input  gpu_pkg::reg_idx_t  rf_waddr,
  input  gpu_pkg::word_t     rf_wdata,
  output gpu_pkg::word_t     rs1_data,
  output gpu_pkg::word_t     rs2_data
);
  import gpu_pkg::*;

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_we && rf_waddr != '0) begin
      regs[rf_waddr] <= rf_wdata;
    end
  end

  // r0 is hardwired to zero
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

// File: core/gpu_exec.sv
`timescale 1ns/1ps

module gpu_exec #(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 10
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  gpu_pkg::tid_t       n_words,
  input  logic [DMEM_AW-1:0]  a_base,
  input  logic [DMEM_AW-1:0]  b_base,
  input  logic [DMEM_AW-1:0]  c_base,
  input  gpu_pkg::instr_t     instr,
  input  gpu_pkg::word_t      rs1_data,
  input  gpu_pkg::word_t      rs2_data,
  input  gpu_pkg::word_t      core_rdata,
  output logic                done,
  output logic                advance,
  output logic                redirect,
  output logic [IMEM_AW-1:0]  redirect_pc,
  output gpu_pkg::reg_idx_t   rs1_idx,
  output gpu_pkg::reg_idx_t   rs2_idx,
  output logic                rf_we,
  output gpu_pkg::reg_idx_t   rf_waddr,
  output gpu_pkg::word_t      rf_wdata,
  output logic                core_we,
  output logic [DMEM_AW-1:0]  core_addr,
  output gpu_pkg::word_t      core_wdata
);
  import gpu_pkg::*;

  localparam int LANE_W = $bits(lane_t);

  typedef enum logic [1:0] {
    S_EXEC,
    S_LD_WAIT,
    S_HALT
  } state_t;

  state_t                 state;
  tid_t                   tid;
  reg_idx_t               ld_dst;

  opcode_t                op;
  reg_idx_t               rd;
  base_sel_t              bsel;
  logic [IMM_HI:IMM_LO]   imm;
  logic signed [15:0]     imm_s;
  logic [DMEM_AW-1:0]     base_addr;
  logic                   active;
  logic                   taken;
  word_t                  alu_y;

  // ====================
  // Decode
  // ====================

  assign op      = opcode_t'(instr[OP_HI:OP_LO]);
  assign rd      = instr[RD_HI:RD_LO];
  assign rs1_idx = instr[RS1_HI:RS1_LO];
  assign rs2_idx = instr[RS2_HI:RS2_LO];
  assign bsel    = base_sel_t'(instr[BSEL_HI:BSEL_LO]);
  assign imm     = instr[IMM_HI:IMM_LO];
  assign imm_s   = signed'(imm);

  assign active = run && (state == S_EXEC);
  assign taken  = active && ((op == BLT && tid < n_words) || op == JMP);

  assign redirect    = taken;
  assign redirect_pc = IMEM_AW'(imm);
  // Load wait finishes even with run low
  assign advance     = (state == S_LD_WAIT) || (active && !taken && op != LD);
  assign done        = (state == S_HALT);

  // ====================
  // Address and store
  // ====================

  always_comb begin
    case (bsel)
      BASE_A:  base_addr = a_base;
      BASE_B:  base_addr = b_base;
      default: base_addr = c_base;
    endcase
  end

  assign core_addr  = base_addr + DMEM_AW'(tid) + DMEM_AW'(imm_s);
  assign core_we    = active && (op == ST);
  assign core_wdata = rs2_data;

  // ====================
  // Lane ALU
  // ====================

  always_comb begin : lane_alu
    lane_t a_l;
    lane_t b_l;
    alu_y = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      a_l = rs1_data[i*LANE_W +: LANE_W];
      b_l = rs2_data[i*LANE_W +: LANE_W];
      case (op)
        ADD:     alu_y[i*LANE_W +: LANE_W] = a_l + b_l;
        SUB:     alu_y[i*LANE_W +: LANE_W] = a_l - b_l;
        // relu, only selected for RELU below
        default: alu_y[i*LANE_W +: LANE_W] = a_l[LANE_W-1] ? '0 : a_l;
      endcase
    end
  end

  always_comb begin
    rf_we    = 1'b0;
    rf_waddr = rd;
    rf_wdata = alu_y;
    if (state == S_LD_WAIT) begin
      rf_we    = 1'b1;
      rf_waddr = ld_dst;
      rf_wdata = core_rdata;
    end else if (active) begin
      case (op)
        LI: begin
          rf_we    = 1'b1;
          rf_wdata = word_t'(imm);
        end
        ADD, SUB, RELU: rf_we = 1'b1;
        default:        rf_we = 1'b0;
      endcase
    end
  end

  // ====================
  // Control state
  // ====================

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_EXEC;
      tid   <= '0;
    end else begin
      case (state)
        S_EXEC: begin
          if (active) begin
            case (op)
              LD:      state <= S_LD_WAIT;
              HALT:    state <= S_HALT;
              SETTID:  tid <= tid_t'(imm);
              INCTID:  tid <= tid + 1'b1;
              default: state <= S_EXEC;
            endcase
          end
        end
        S_LD_WAIT: state <= S_EXEC;
        default:   state <= S_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (active && op == LD) begin
      ld_dst <= rd;
    end
  end

  // The load word stays on instr through its wait, so no store goes out
  a_ld_wait: assert property (
    @(posedge clk) disable iff (rst)
    (state == S_LD_WAIT) |-> (op == LD && !core_we)
  );

endmodule

// File: hdl/gpu_top.sv
`timescale 1ns/1ps

module gpu_top #(
  parameter int IMEM_AW = 8,
  parameter int DMEM_AW = 10
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  gpu_pkg::tid_t       n_words,
  input  logic [DMEM_AW-1:0]  a_base,
  input  logic [DMEM_AW-1:0]  b_base,
  input  logic [DMEM_AW-1:0]  c_base,
  output logic                done,
  input  logic                imem_we,
  input  logic [IMEM_AW-1:0]  imem_waddr,
  input  gpu_pkg::instr_t     imem_wdata,
  input  logic                host_dmem_we,
  input  logic [DMEM_AW-1:0]  host_dmem_addr,
  input  gpu_pkg::word_t      host_dmem_wdata,
  output gpu_pkg::word_t      host_dmem_rdata
);
  import gpu_pkg::*;

  instr_t             instr;
  logic               advance;
  logic               redirect;
  logic [IMEM_AW-1:0] redirect_pc;

  reg_idx_t           rs1_idx;
  reg_idx_t           rs2_idx;
  word_t              rs1_data;
  word_t              rs2_data;
  logic               rf_we;
  reg_idx_t           rf_waddr;
  word_t              rf_wdata;

  logic               core_we;
  logic [DMEM_AW-1:0] core_addr;
  word_t              core_wdata;
  word_t              core_rdata;

  gpu_fetch #(.IMEM_AW(IMEM_AW)) u_fetch (
    .clk         (clk),
    .rst         (rst),
    .imem_we     (imem_we),
    .imem_waddr  (imem_waddr),
    .imem_wdata  (imem_wdata),
    .advance     (advance),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .instr       (instr)
  );

  gpu_regfile u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rf_we    (rf_we),
    .rf_waddr (rf_waddr),
    .rf_wdata (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  gpu_exec #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_exec (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .n_words     (n_words),
    .a_base      (a_base),
    .b_base      (b_base),
    .c_base      (c_base),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .core_rdata  (core_rdata),
    .done        (done),
    .advance     (advance),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rf_we       (rf_we),
    .rf_waddr    (rf_waddr),
    .rf_wdata    (rf_wdata),
    .core_we     (core_we),
    .core_addr   (core_addr),
    .core_wdata  (core_wdata)
  );

  gpu_dmem #(.DMEM_AW(DMEM_AW)) u_dmem (
    .clk             (clk),
    .core_we         (core_we),
    .core_addr       (core_addr),
    .core_wdata      (core_wdata),
    .core_rdata      (core_rdata),
    .host_dmem_we    (host_dmem_we),
    .host_dmem_addr  (host_dmem_addr),
    .host_dmem_wdata (host_dmem_wdata),
    .host_dmem_rdata (host_dmem_rdata)
  );

endmodule

// File: test/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Kernel selectors
localparam int K_ADD  = 0;
localparam int K_SUB  = 1;
localparam int K_RELU = 2;
localparam int K_IMM  = 3;

localparam logic [15:0] LI_PATTERN = 16'hC3A5;

function automatic instr_t encode(opcode_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                  base_sel_t bsel, logic [15:0] imm);
  instr_t w;
  w = INSTR_NOP;
  w[OP_HI:OP_LO]     = op;
  w[RD_HI:RD_LO]     = rd;
  w[RS1_HI:RS1_LO]   = rs1;
  w[RS2_HI:RS2_LO]   = rs2;
  w[BSEL_HI:BSEL_LO] = bsel;
  w[IMM_HI:IMM_LO]   = imm;
  return w;
endfunction

function automatic instr_t ctrl_instr(opcode_t op, logic [15:0] imm);
  return encode(op, 3'd0, 3'd0, 3'd0, BASE_A, imm);
endfunction

function automatic instr_t load_instr(reg_idx_t rd, base_sel_t bsel);
  return encode(LD, rd, 3'd0, 3'd0, bsel, 16'd0);
endfunction

function automatic instr_t store_instr(reg_idx_t rs2, base_sel_t bsel, logic [15:0] off);
  return encode(ST, 3'd0, 3'd0, rs2, bsel, off);
endfunction

function automatic instr_t alu_instr(opcode_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
  return encode(op, rd, rs1, rs2, BASE_A, 16'd0);
endfunction

// c[tid] = a[tid] op b[tid] for every tid below n_words
function automatic instr_t binop_word(opcode_t op, int pc);
  instr_t w;
  case (pc)
    0:       w = ctrl_instr(SETTID, 16'd0);
    1:       w = load_instr(3'd1, BASE_A);
    2:       w = load_instr(3'd2, BASE_B);
    3:       w = alu_instr(op, 3'd3, 3'd1, 3'd2);
    4:       w = store_instr(3'd3, BASE_C, 16'd0);
    5:       w = ctrl_instr(INCTID, 16'd0);
    6:       w = ctrl_instr(BLT, 16'd1);
    default: w = ctrl_instr(HALT, 16'd0);
  endcase
  return w;
endfunction

function automatic instr_t relu_word(int pc);
  instr_t w;
  case (pc)
    0:       w = ctrl_instr(SETTID, 16'd0);
    1:       w = load_instr(3'd1, BASE_A);
    2:       w = alu_instr(RELU, 3'd4, 3'd1, 3'd0);
    3:       w = store_instr(3'd4, BASE_C, 16'd0);
    4:       w = ctrl_instr(INCTID, 16'd0);
    5:       w = ctrl_instr(BLT, 16'd1);
    default: w = ctrl_instr(HALT, 16'd0);
  endcase
  return w;
endfunction

// Words 6 and 7 are the killed slot and the jumped-over store
function automatic instr_t imm_word(int pc);
  instr_t w;
  case (pc)
    0:       w = ctrl_instr(SETTID, 16'd0);
    1:       w = encode(LI, 3'd1, 3'd0, 3'd0, BASE_A, LI_PATTERN);
    2:       w = encode(LI, 3'd0, 3'd0, 3'd0, BASE_A, 16'h7FFF);
    3:       w = store_instr(3'd1, BASE_C, 16'd0);
    4:       w = store_instr(3'd0, BASE_C, 16'd1);
    5:       w = ctrl_instr(JMP, 16'd8);
    6:       w = store_instr(3'd1, BASE_C, 16'd2);
    7:       w = store_instr(3'd1, BASE_C, 16'd3);
    default: w = ctrl_instr(HALT, 16'd0);
  endcase
  return w;
endfunction

function automatic int kernel_len(int kind);
  if (kind == K_RELU) return 7;
  if (kind == K_IMM) return 9;
  return 8;
endfunction

function automatic instr_t kernel_word(int kind, int pc);
  instr_t w;
  case (kind)
    K_ADD:   w = binop_word(ADD, pc);
    K_SUB:   w = binop_word(SUB, pc);
    K_RELU:  w = relu_word(pc);
    default: w = imm_word(pc);
  endcase
  return w;
endfunction

`endif

// File: test/tb_gpu.sv
`timescale 1ns/1ps

module tb_gpu;
  import gpu_pkg::*;

  localparam int IMEM_AW = 8;
  localparam int DMEM_AW = 10;
  localparam int LANE_W  = $bits(lane_t);

  // Lane pairs that overflow on add or subtract
  localparam word_t EDGE_A = 64'h7FFF_8000_7FFF_8000;
  localparam word_t EDGE_B = 64'h0001_0001_8000_7FFF;

  `include "tb_programs.svh"

  logic               clk = 1'b0;
  logic               rst;
  logic               run;
  tid_t               n_words;
  logic [DMEM_AW-1:0] a_base;
  logic [DMEM_AW-1:0] b_base;
  logic [DMEM_AW-1:0] c_base;
  logic               done;
  logic               imem_we;
  logic [IMEM_AW-1:0] imem_waddr;
  instr_t             imem_wdata;
  logic               host_dmem_we;
  logic [DMEM_AW-1:0] host_dmem_addr;
  word_t              host_dmem_wdata;
  word_t              host_dmem_rdata;

  // Expected contents of data memory
  word_t exp_mem [2**DMEM_AW];
  logic  chk_valid;
  int    chk_addr;
  logic  rd_v = 1'b0;
  int    rd_a;
  int    word_checks;
  int    word_errors;
  int    done_checks;
  int    done_errors;
  int    limit_cycles;
  int    n_list [4];

  gpu_top #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) u_dut (.*);

  always #5 clk = ~clk;

  // ====================
  // Reference and checks
  // ====================

  function automatic word_t ref_word(opcode_t op, word_t a, word_t b);
    word_t r;
    lane_t a_l;
    lane_t b_l;
    int    s;
    r = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      a_l = a[i*LANE_W +: LANE_W];
      b_l = b[i*LANE_W +: LANE_W];
      if (op == ADD) begin
        s = int'(a_l) + int'(b_l);
      end else if (op == SUB) begin
        s = int'(a_l) - int'(b_l);
      end else begin
        s = (a_l < 0) ? 0 : int'(a_l);
      end
      // Low 16 bits only, so sums wrap
      r[i*LANE_W +: LANE_W] = s[LANE_W-1:0];
    end
    return r;
  endfunction

  function automatic word_t sentinel(int addr);
    return {32'h5E47_1E00, 22'd0, addr[DMEM_AW-1:0]};
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    word_checks++;
    if (got !== exp) begin
      word_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_done(input logic got, input logic exp);
    done_checks++;
    if (got !== exp) begin
      done_errors++;
      $display("Mismatch at %0t: done got %b expected %b", $time, got, exp);
    end
  endtask

  // Host read data lags the address by one cycle
  always @(posedge clk) begin
    rd_v <= chk_valid;
    rd_a <= chk_addr;
  end

  always @(negedge clk) begin
    if (rd_v) begin
      check_word($sformatf("host_dmem_rdata[%0d]", rd_a), host_dmem_rdata, exp_mem[rd_a]);
    end
  end

  // ====================
  // Host side tasks
  // ====================

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    run = 1'b0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic load_program(input int kind);
    for (int pc = 0; pc < kernel_len(kind); pc++) begin
      @(negedge clk);
      imem_we    = 1'b1;
      imem_waddr = IMEM_AW'(pc);
      imem_wdata = kernel_word(kind, pc);
    end
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  task automatic write_dmem(input int addr, input word_t data);
    @(negedge clk);
    host_dmem_we    = 1'b1;
    host_dmem_addr  = DMEM_AW'(addr);
    host_dmem_wdata = data;
    exp_mem[addr]   = data;
  endtask

  task automatic read_dmem(input int addr);
    @(negedge clk);
    chk_valid      = 1'b1;
    chk_addr       = addr;
    host_dmem_addr = DMEM_AW'(addr);
  endtask

  task automatic run_kernel(input int kind, input int n);
    int      a;
    int      b;
    int      c;
    opcode_t op;
    apply_reset();
    check_done(done, 1'b0);
    a = $urandom_range(200, 0);
    b = 256 + $urandom_range(200, 0);
    c = 520 + $urandom_range(200, 0);
    $display("Kernel %0d: n_words %0d, c_base %0d", kind, n, c);
    load_program(kind);
    if (kind != K_IMM) begin
      for (int i = 0; i < n; i++) begin
        write_dmem(a + i, (i == 0) ? EDGE_A : {$urandom, $urandom});
        write_dmem(b + i, (i == 0) ? EDGE_B : {$urandom, $urandom});
      end
    end
    // Sentinels below c_base and past the last index
    for (int addr = c - 2; addr < c + n + 4; addr++) begin
      write_dmem(addr, sentinel(addr));
    end
    @(negedge clk);
    host_dmem_we = 1'b0;
    n_words      = tid_t'(n);
    a_base       = DMEM_AW'(a);
    b_base       = DMEM_AW'(b);
    c_base       = DMEM_AW'(c);
    run          = 1'b1;
    while (done !== 1'b1) begin
      @(negedge clk);
    end
    repeat (20) begin
      @(negedge clk);
      check_done(done, 1'b1);
    end
    run = 1'b0;
    if (kind == K_IMM) begin
      exp_mem[c]     = word_t'(LI_PATTERN);
      exp_mem[c + 1] = '0;
    end else begin
      if (kind == K_ADD) begin
        op = ADD;
      end else if (kind == K_SUB) begin
        op = SUB;
      end else begin
        op = RELU;
      end
      for (int i = 0; i < n; i++) begin
        exp_mem[c + i] = ref_word(op, exp_mem[a + i], exp_mem[b + i]);
      end
    end
    for (int addr = c - 2; addr < c + n + 4; addr++) begin
      read_dmem(addr);
    end
    @(negedge clk);
    chk_valid = 1'b0;
    @(negedge clk);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    int total;
    void'($urandom(63));
    rst             = 1'b1;
    run             = 1'b0;
    n_words         = '0;
    a_base          = '0;
    b_base          = '0;
    c_base          = '0;
    imem_we         = 1'b0;
    imem_waddr      = '0;
    imem_wdata      = '0;
    host_dmem_we    = 1'b0;
    host_dmem_addr  = '0;
    host_dmem_wdata = '0;
    chk_valid       = 1'b0;
    chk_addr        = 0;
    total           = 0;
    for (int k = K_ADD; k <= K_IMM; k++) begin
      if (k == K_IMM) begin
        n_list[k] = 2;
      end else begin
        n_list[k] = $urandom_range(40, 4);
      end
      total += n_list[k];
    end
    limit_cycles = 200 * total + 2000;
    for (int k = K_ADD; k <= K_IMM; k++) begin
      run_kernel(k, n_list[k]);
    end
    $display("word checks %0d, word errors %0d, done checks %0d, done errors %0d",
             word_checks, word_errors, done_checks, done_errors);
    if (word_errors == 0 && done_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: the kernels did not finish within %0d cycles", limit_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

// File: gpu_lite.f
+incdir+test
common/gpu_pkg.sv
hdl/gpu_dmem.sv
core/gpu_fetch.sv
core/gpu_regfile.sv
core/gpu_exec.sv
hdl/gpu_top.sv
test/tb_gpu.sv

// File: Makefile
TOP := tb_gpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f gpu_lite.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f gpu_lite.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
